// ==== ByteMem.sv ====
`timescale 1ns/1ps
`default_nettype none

module ByteMem #(
   parameter int ADDR_WIDTH = 10
) (
   input  logic                  clk,
   input  memAccessPkg::byteEn_t writeEn,
   input  logic [ADDR_WIDTH-1:0] writeAddr,
   input  memAccessPkg::word_t   writeData,
   input  logic [ADDR_WIDTH-1:0] readAddr,
   output memAccessPkg::word_t   readData
);

   localparam int DEPTH = 2 ** ADDR_WIDTH;

   memAccessPkg::word_t mem [DEPTH];

   // writeEn bit n drives bits 8n+7..8n, so bit 3 is the msb lane
   always_ff @(posedge clk) begin
      for (int lane = 0; lane < 4; lane++) begin
         if (writeEn[lane]) begin
            mem[writeAddr][lane*8 +: 8] <= writeData[lane*8 +: 8];
         end
      end
   end

   // registered read, returns old word on a same-cycle write
   always_ff @(posedge clk) begin
      readData <= mem[readAddr];
   end

   // an X on a lane enable would corrupt memory silently
   assert property (@(posedge clk) !$isunknown(writeEn))
      else $error("ByteMem: writeEn unknown");

endmodule

`default_nettype wire

// ==== LoadExtract.sv ====
`timescale 1ns/1ps
`default_nettype none

module LoadExtract (
   input  memAccessPkg::loadCtl_t ctl,
   input  memAccessPkg::word_t    readWord,
   output memAccessPkg::word_t    loadData
);

   logic [7:0]  selByte;
   logic [15:0] selHalf;

   // offset 0 addresses bits 31..24, so the lane index is the inverted offset
   assign selByte = readWord[{~ctl.byteOffset, 3'b000} +: 8];

   assign selHalf = ctl.byteOffset[1] ? readWord[15:0] : readWord[31:16];

   always_comb begin
      case (ctl.opcode)
         memAccessPkg::OP_LB: begin
            loadData = {{24{selByte[7]}}, selByte};   // sign extend
         end
         memAccessPkg::OP_LBU: begin
            loadData = {24'h000000, selByte};
         end
         memAccessPkg::OP_LH: begin
            loadData = {{16{selHalf[15]}}, selHalf};
         end
         memAccessPkg::OP_LHU: begin
            loadData = {16'h0000, selHalf};
         end
         memAccessPkg::OP_LW: begin
            loadData = readWord;                      // low offset bits ignored
         end
         default: begin
            loadData = 32'h0000_0000;                 // not a load
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = MemStageTb
FILELIST  = all.f
OBJDIR    = obj_dir
LOG       = sim.log
PASS      = TEST OK

SOURCES = $(wildcard *.sv) $(wildcard *.svh)
BINARY  = $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

# the log decides pass or fail, not the simulator exit code
run: compile
	./$(BINARY) | tee $(LOG)
	@grep -qx "$(PASS)" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== MemStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module MemStage #(
   parameter int ADDR_WIDTH = 10
) (
   input  logic                   clk,
   input  logic                   reset,
   input  memAccessPkg::opcode_t  opcode,
   input  memAccessPkg::memAddr_u ALUOut,
   input  memAccessPkg::word_t    storeData,
   input  memAccessPkg::word_t    pc,
   output memAccessPkg::word_t    loadData,
   output memAccessPkg::word_t    instr
);

   memAccessPkg::byteEn_t  dataMemWriteEn;
   memAccessPkg::byteEn_t  instrMemWriteEn;
   memAccessPkg::word_t    alignedData;
   memAccessPkg::word_t    dataReadWord;
   memAccessPkg::memAddr_u pcAddr;
   memAccessPkg::loadCtl_t loadCtlQ;         // request cycle -> data cycle
   logic [ADDR_WIDTH-1:0]  dataIndex;
   logic [ADDR_WIDTH-1:0]  pcIndex;

   assign pcAddr.raw = pc;
   assign dataIndex  = ALUOut.fields.wordIndex[ADDR_WIDTH-1:0];
   assign pcIndex    = pcAddr.fields.wordIndex[ADDR_WIDTH-1:0];

   WriteEnCtr writeEnCtr (
      .opcode          (opcode),
      .byteOffset      (ALUOut.fields.byteOffset),
      .ALUOut          (ALUOut),
      .dataMemWriteEn  (dataMemWriteEn),
      .instrMemWriteEn (instrMemWriteEn)
   );

   StoreAlign storeAlign (
      .opcode      (opcode),
      .storeData   (storeData),
      .alignedData (alignedData)
   );

   ByteMem #(.ADDR_WIDTH(ADDR_WIDTH)) dataMem (
      .clk       (clk),
      .writeEn   (dataMemWriteEn),
      .writeAddr (dataIndex),
      .writeData (alignedData),
      .readAddr  (dataIndex),
      .readData  (dataReadWord)
   );

   // instruction memory is written through the data path, read by fetch
   ByteMem #(.ADDR_WIDTH(ADDR_WIDTH)) instrMem (
      .clk       (clk),
      .writeEn   (instrMemWriteEn),
      .writeAddr (dataIndex),
      .writeData (alignedData),
      .readAddr  (pcIndex),
      .readData  (instr)
   );

   always_ff @(posedge clk) begin
      if (reset) begin
         loadCtlQ <= '0;                        // opcode 0 is not a load
      end else begin
         loadCtlQ.opcode     <= opcode;
         loadCtlQ.byteOffset <= ALUOut.fields.byteOffset;
      end
   end

   LoadExtract loadExtract (
      .ctl      (loadCtlQ),
      .readWord (dataReadWord),
      .loadData (loadData)
   );

   // a load must never disturb either memory
   assert property (@(posedge clk) disable iff (reset)
      memAccessPkg::isLoadOp(opcode) |-> (dataMemWriteEn == 4'b0000 &&
                                          instrMemWriteEn == 4'b0000))
      else $error("MemStage: write mask during load");

endmodule

`default_nettype wire

// ==== memStageVectors.svh ====
`ifndef MEM_STAGE_VECTORS_SVH
`define MEM_STAGE_VECTORS_SVH

// columns: opcode, address (also driven as pc), store data, check kind, expected word
// each row is applied for one cycle and its result is checked one cycle later

localparam int NUM_VECTORS = 38;

localparam vecEntry_t VECTORS [NUM_VECTORS] = '{
   // partial stores into word 4
   '{memAccessPkg::OP_SW,  32'h1000_0010, 32'h1122_3344, CHK_NONE,  32'h0000_0000},
   '{memAccessPkg::OP_SB,  32'h1000_0010, 32'h0000_00AA, CHK_NONE,  32'h0000_0000},
   '{memAccessPkg::OP_SB,  32'h1000_0011, 32'h0000_00BB, CHK_NONE,  32'h0000_0000},
   '{memAccessPkg::OP_SB,  32'h1000_0012, 32'h0000_00CC, CHK_NONE,  32'h0000_0000},
   '{memAccessPkg::OP_SB,  32'h1000_0013, 32'h0000_00DD, CHK_NONE,  32'h0000_0000},
   '{memAccessPkg::OP_LW,  32'h1000_0010, 32'h0000_0000, CHK_LOAD,  32'hAABB_CCDD},
   '{memAccessPkg::OP_SH,  32'h1000_0010, 32'h0000_1234, CHK_NONE,  32'h0000_0000},
   '{memAccessPkg::OP_SH,  32'h1000_0012, 32'h0000_5678, CHK_NONE,  32'h0000_0000},
   '{memAccessPkg::OP_LW,  32'h1000_0010, 32'h0000_0000, CHK_LOAD,  32'h1234_5678},
   // extraction from word 8, every byte and half has its top bit set
   '{memAccessPkg::OP_SW,  32'h1000_0020, 32'h8AF0_9CE5, CHK_NONE,  32'h0000_0000},
   '{memAccessPkg::OP_LB,  32'h1000_0020, 32'h0000_0000, CHK_LOAD,  32'hFFFF_FF8A},
   '{memAccessPkg::OP_LB,  32'h1000_0021, 32'h0000_0000, CHK_LOAD,  32'hFFFF_FFF0},
   '{memAccessPkg::OP_LB,  32'h1000_0022, 32'h0000_0000, CHK_LOAD,  32'hFFFF_FF9C},
   '{memAccessPkg::OP_LB,  32'h1000_0023, 32'h0000_0000, CHK_LOAD,  32'hFFFF_FFE5},
   '{memAccessPkg::OP_LBU, 32'h1000_0020, 32'h0000_0000, CHK_LOAD,  32'h0000_008A},
   '{memAccessPkg::OP_LBU, 32'h1000_0021, 32'h0000_0000, CHK_LOAD,  32'h0000_00F0},
   '{memAccessPkg::OP_LBU, 32'h1000_0022, 32'h0000_0000, CHK_LOAD,  32'h0000_009C},
   '{memAccessPkg::OP_LBU, 32'h1000_0023, 32'h0000_0000, CHK_LOAD,  32'h0000_00E5},
   '{memAccessPkg::OP_LH,  32'h1000_0020, 32'h0000_0000, CHK_LOAD,  32'hFFFF_8AF0},
   '{memAccessPkg::OP_LH,  32'h1000_0022, 32'h0000_0000, CHK_LOAD,  32'hFFFF_9CE5},
   '{memAccessPkg::OP_LHU, 32'h1000_0020, 32'h0000_0000, CHK_LOAD,  32'h0000_8AF0},
   '{memAccessPkg::OP_LHU, 32'h1000_0022, 32'h0000_0000, CHK_LOAD,  32'h0000_9CE5},
   // region decoding on word 12 of both memories
   '{memAccessPkg::OP_SW,  32'h1000_0030, 32'h0BAD_0BAD, CHK_NONE,  32'h0000_0000},
   '{memAccessPkg::OP_SW,  32'h2000_0030, 32'hCAFE_0001, CHK_NONE,  32'h0000_0000},
   '{memAccessPkg::OP_LW,  32'h1000_0030, 32'h0000_0000, CHK_LOAD,  32'h0BAD_0BAD},
   '{OP_NOP,               32'h0000_0030, 32'h0000_0000, CHK_INSTR, 32'hCAFE_0001},
   '{memAccessPkg::OP_SW,  32'h1000_0030, 32'h1111_0000, CHK_NONE,  32'h0000_0000},
   '{memAccessPkg::OP_LW,  32'h1000_0030, 32'h0000_0000, CHK_LOAD,  32'h1111_0000},
   '{OP_NOP,               32'h0000_0030, 32'h0000_0000, CHK_INSTR, 32'hCAFE_0001},
   '{memAccessPkg::OP_SW,  32'h3000_0030, 32'h3333_0003, CHK_NONE,  32'h0000_0000},
   '{memAccessPkg::OP_LW,  32'h1000_0030, 32'h0000_0000, CHK_LOAD,  32'h3333_0003},
   '{OP_NOP,               32'h0000_0030, 32'h0000_0000, CHK_INSTR, 32'h3333_0003},
   '{memAccessPkg::OP_SW,  32'h8000_0030, 32'h8888_0008, CHK_NONE,  32'h0000_0000},
   '{memAccessPkg::OP_LW,  32'h1000_0030, 32'h0000_0000, CHK_LOAD,  32'h3333_0003},
   '{OP_NOP,               32'h0000_0030, 32'h0000_0000, CHK_INSTR, 32'h3333_0003},
   // back-to-back loads
   '{memAccessPkg::OP_LW,  32'h1000_0010, 32'h0000_0000, CHK_LOAD,  32'h1234_5678},
   '{memAccessPkg::OP_LW,  32'h1000_0020, 32'h0000_0000, CHK_LOAD,  32'h8AF0_9CE5},
   '{memAccessPkg::OP_LW,  32'h1000_0030, 32'h0000_0000, CHK_LOAD,  32'h3333_0003}
};

`endif

// ==== MemStageTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module MemStageTb;

   localparam int ADDR_WIDTH    = 10;
   localparam int RESET_CYCLES  = 4;
   localparam int READY_TIMEOUT = 20;      // cycles to leave reset
   localparam int RANDOM_PAIRS  = 32;
   localparam logic [31:0] LCG_SEED = 32'd30250;

   localparam memAccessPkg::opcode_t OP_NOP = 6'h00;   // not a load, not a store

   localparam logic [1:0] CHK_NONE  = 2'd0;
   localparam logic [1:0] CHK_LOAD  = 2'd1;
   localparam logic [1:0] CHK_INSTR = 2'd2;

   typedef struct packed {
      memAccessPkg::opcode_t opcode;
      memAccessPkg::word_t   addr;
      memAccessPkg::word_t   data;
      logic [1:0]            check;    // which output the next cycle shows
      memAccessPkg::word_t   expected;
   } vecEntry_t;

   `include "memStageVectors.svh"

   logic                   clk;
   logic                   reset;
   memAccessPkg::opcode_t  opcode;
   memAccessPkg::memAddr_u ALUOut;
   memAccessPkg::word_t    storeData;
   memAccessPkg::word_t    pc;
   memAccessPkg::word_t    loadData;
   memAccessPkg::word_t    instr;

   int          loadErrors;
   int          instrErrors;
   logic        ready;
   logic [31:0] lcgState;

   MemStage #(.ADDR_WIDTH(ADDR_WIDTH)) UUT (
      .clk       (clk),
      .reset     (reset),
      .opcode    (opcode),
      .ALUOut    (ALUOut),
      .storeData (storeData),
      .pc        (pc),
      .loadData  (loadData),
      .instr     (instr)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;   // 100 ns period
   end

   function automatic logic [31:0] lcgNext(input logic [31:0] state);
      lcgNext = state * 32'd1103515245 + 32'd12345;
   endfunction

   // pc follows the address so fetch rows can reuse the address column
   task automatic driveOp(input memAccessPkg::opcode_t op, input memAccessPkg::word_t addr,
                          input memAccessPkg::word_t data);
      opcode     = op;
      ALUOut.raw = addr;
      storeData  = data;
      pc         = addr;
   endtask

   task automatic checkLoad(input memAccessPkg::word_t actual,
                            input memAccessPkg::word_t expected, input string what);
      if (actual !== expected) begin
         $display("FAILED at %0t: %s loadData = %h, expected %h",
                  $time, what, actual, expected);
         loadErrors++;
      end
   endtask

   task automatic checkInstr(input memAccessPkg::word_t actual,
                             input memAccessPkg::word_t expected, input string what);
      if (actual !== expected) begin
         $display("FAILED at %0t: %s instr = %h, expected %h",
                  $time, what, actual, expected);
         instrErrors++;
      end
   endtask

   task automatic checkEntry(input vecEntry_t entry, input int idx);
      case (entry.check)
         CHK_LOAD:  checkLoad(loadData, entry.expected, $sformatf("vector %0d", idx));
         CHK_INSTR: checkInstr(instr, entry.expected, $sformatf("vector %0d", idx));
         default:   ;   // stores have nothing to show yet
      endcase
   endtask

   task automatic applyReset;
      reset = 1'b1;
      for (int n = 0; n < RESET_CYCLES; n++) begin
         @(negedge clk);
      end
      reset = 1'b0;
   endtask

   task automatic waitReady(output logic isReady);
      int cycles;
      isReady = 1'b0;
      cycles  = 0;
      while (!isReady && cycles < READY_TIMEOUT) begin
         @(negedge clk);
         cycles++;
         if (!reset && !$isunknown(loadData)) begin
            isReady = 1'b1;
         end
      end
   endtask

   // row i is driven on one falling edge and checked on the next
   task automatic runTable;
      for (int i = 0; i <= NUM_VECTORS; i++) begin
         @(negedge clk);
         if (i > 0) begin
            checkEntry(VECTORS[i-1], i - 1);
         end
         if (i < NUM_VECTORS) begin
            driveOp(VECTORS[i].opcode, VECTORS[i].addr, VECTORS[i].data);
         end else begin
            driveOp(OP_NOP, 32'h0000_0000, 32'h0000_0000);
         end
      end
   endtask

   task automatic runRandom;
      memAccessPkg::word_t addr;
      memAccessPkg::word_t data;
      for (int n = 0; n < RANDOM_PAIRS; n++) begin
         lcgState = lcgNext(lcgState);
         addr     = {4'h1, 16'h0000, lcgState[25:16], 2'b00};   // data region, aligned
         lcgState = lcgNext(lcgState);
         data     = lcgState;
         @(negedge clk);
         driveOp(memAccessPkg::OP_SW, addr, data);
         @(negedge clk);
         driveOp(memAccessPkg::OP_LW, addr, 32'h0000_0000);
         @(negedge clk);
         // sw writes all four lanes, so lw returns the stored word unchanged
         checkLoad(loadData, data, $sformatf("random pair %0d at %h", n, addr));
         driveOp(OP_NOP, 32'h0000_0000, 32'h0000_0000);
      end
   endtask

   initial begin
      reset       = 1'b1;
      loadErrors  = 0;
      instrErrors = 0;
      lcgState    = LCG_SEED;
      // a load held through reset must not reach loadData
      driveOp(memAccessPkg::OP_LW, 32'h1000_0000, 32'h0000_0000);
      applyReset();
      checkLoad(loadData, 32'h0000_0000, "after reset");
      driveOp(OP_NOP, 32'h0000_0000, 32'h0000_0000);
      waitReady(ready);
      if (!ready) begin
         $display("stage did not leave reset within %0d cycles", READY_TIMEOUT);
         $display("TEST FAILED");
      end else begin
         runTable();
         runRandom();
         $display("errors: load %0d, instr %0d, total %0d",
                  loadErrors, instrErrors, loadErrors + instrErrors);
         if (loadErrors + instrErrors == 0) begin
            $display("TEST OK");
         end else begin
            $display("TEST FAILED");
         end
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== StoreAlign.sv ====
`timescale 1ns/1ps
`default_nettype none

// Copies the store operand into every lane it could land in. The
// write masks from WriteEnCtr decide which lanes are actually written.
module StoreAlign (
   input  memAccessPkg::opcode_t opcode,
   input  memAccessPkg::word_t   storeData,
   output memAccessPkg::word_t   alignedData
);

   logic [7:0]  lowByte;
   logic [15:0] lowHalf;

   assign lowByte = storeData[7:0];
   assign lowHalf = storeData[15:0];

   always_comb begin
      case (opcode)
         memAccessPkg::OP_SB: begin
            alignedData = {4{lowByte}};   // byte in all four lanes
         end
         memAccessPkg::OP_SH: begin
            alignedData = {2{lowHalf}};   // both halves
         end
         default: begin
            alignedData = storeData;      // sw, or masks are zero anyway
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== WriteEnCtr.sv ====
`timescale 1ns/1ps
`default_nettype none

module WriteEnCtr (
   input  memAccessPkg::opcode_t  opcode,
   input  logic [1:0]             byteOffset,
   input  memAccessPkg::memAddr_u ALUOut,
   output memAccessPkg::byteEn_t  dataMemWriteEn,
   output memAccessPkg::byteEn_t  instrMemWriteEn
);

   logic [3:0]            topNibble;
   logic                  isDataMem;
   logic                  isInstrMem;
   memAccessPkg::byteEn_t storeMask;   // lanes touched, before region gating

   assign topNibble  = ALUOut.fields.topNibble;
   assign isDataMem  = ~topNibble[3] & topNibble[0];   // 0x1, 0x3, 0x5, 0x7
   assign isInstrMem = ~topNibble[3] & topNibble[1];   // 0x2, 0x3, 0x6, 0x7

   // one mask for both memories, the region only gates it
   always_comb begin
      case (opcode)
         memAccessPkg::OP_SB: begin
            storeMask = 4'b1000 >> byteOffset;   // offset 0 is the msb lane
         end
         memAccessPkg::OP_SH: begin
            if (byteOffset[1]) begin             // halfword chosen by bit 1
               storeMask = 4'b0011;
            end else begin
               storeMask = 4'b1100;
            end
         end
         memAccessPkg::OP_SW: begin
            storeMask = 4'b1111;
         end
         default: begin
            storeMask = 4'b0000;                 // loads and everything else
         end
      endcase
   end

   assign dataMemWriteEn  = isDataMem  ? storeMask : 4'b0000;
   assign instrMemWriteEn = isInstrMem ? storeMask : 4'b0000;

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+.
memAccessPkg.sv
WriteEnCtr.sv
StoreAlign.sv
ByteMem.sv
LoadExtract.sv
MemStage.sv
MemStageTb.sv

// ==== memAccessPkg.sv ====
`default_nettype none

package memAccessPkg;

   typedef logic [31:0] word_t;
   typedef logic [5:0]  opcode_t;

   // bit 3 is the byte at offset 0 (big-endian)
   typedef logic [3:0]  byteEn_t;

   // primary opcodes used by the memory stage
   localparam opcode_t OP_LB  = 6'h20;
   localparam opcode_t OP_LH  = 6'h21;
   localparam opcode_t OP_LW  = 6'h23;
   localparam opcode_t OP_LBU = 6'h24;
   localparam opcode_t OP_LHU = 6'h25;
   localparam opcode_t OP_SB  = 6'h28;
   localparam opcode_t OP_SH  = 6'h29;
   localparam opcode_t OP_SW  = 6'h2B;

   typedef struct packed {
      logic [3:0]  topNibble;   // region select
      logic [25:0] wordIndex;
      logic [1:0]  byteOffset;
   } addrFields_t;

   // one ALU address, seen whole or split into memory fields
   typedef union packed {
      word_t       raw;
      addrFields_t fields;
   } memAddr_u;

   // load request carried to the cycle the read word comes back
   typedef struct packed {
      opcode_t    opcode;
      logic [1:0] byteOffset;
   } loadCtl_t;

   function automatic logic isLoadOp(input opcode_t op);
      case (op)
         OP_LB,
         OP_LH,
         OP_LW,
         OP_LBU,
         OP_LHU:  isLoadOp = 1'b1;
         default: isLoadOp = 1'b0;
      endcase
   endfunction

endpackage

`default_nettype wire
